//--- Bender.yml
package:
  name: trellis_front_end

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/trellisFrontPkg.sv
      - logic/dualReadSampleRam.sv
      - logic/pilotFrameTimer.sv
      - logic/frameAlignment.sv
      - logic/tapCombiner.sv
      - logic/trellisFrontEnd.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/trellisFrontEnd_chk.sv
      - testbench/trellisFrontEndTb.sv

//--- build.f
+incdir+logic
logic/trellisFrontPkg.sv
logic/dualReadSampleRam.sv
logic/pilotFrameTimer.sv
logic/frameAlignment.sv
logic/tapCombiner.sv
logic/trellisFrontEnd.sv
testbench/trellisFrontEnd_chk.sv
testbench/trellisFrontEndTb.sv

//--- logic/dualReadSampleRam.sv
`default_nettype none
`include "trellisFront_defines.svh"

module dualReadSampleRam (
    input  wire                               clk,
    input  wire                               clkEn,
    input  wire                               writeEnable,
    input  wire  trellisFrontPkg::sampleAddr_t writeAddr,
    input  wire  trellisFrontPkg::sampleAddr_t readAddrA,
    input  wire  trellisFrontPkg::sampleAddr_t readAddrB,
    input  wire  trellisFrontPkg::iqSample_t   writeData,
    output trellisFrontPkg::iqSample_t         readDataA,
    output trellisFrontPkg::iqSample_t         readDataB
);
    import trellisFrontPkg::*;

    localparam int DEPTH = 2 ** `ADDR_WIDTH;

    iqSample_t mem [DEPTH];   // addresses wrap on their own at full depth

    always_ff @(posedge clk) begin
        if (clkEn && writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // both read ports registered, a read of the address being
    // written returns the old word
    always_ff @(posedge clk) begin
        if (clkEn) begin
            readDataA <= mem[readAddrA];
            readDataB <= mem[readAddrB];
        end
    end

endmodule

`default_nettype wire

//--- logic/frameAlignment.sv
`default_nettype none
`include "trellisFront_defines.svh"

module frameAlignment #(
    parameter int CLKS_PER_OUTPUT = 2
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              clkEn,
    input  wire                              valid,
    input  wire                              startOfFrame,
    input  wire                              estimatesDone,
    input  wire  trellisFrontPkg::iqSample_t sampleIn,
    input  wire  trellisFrontPkg::tapIndex_t startOffset,
    input  wire  trellisFrontPkg::tapIndex_t tapIndex0,
    input  wire  trellisFrontPkg::tapIndex_t tapIndex1,
    output trellisFrontPkg::tapPair_t        taps,
    output logic                             tapStrobe,
    output logic                             interpolate,
    output logic                             startOfTrellis,
    output logic                             full
);
    import trellisFrontPkg::*;

    localparam int WARM_W     = $clog2(`TRELLIS_INIT_CYCLES + 1);
    localparam int DEC_W      = $clog2(CLKS_PER_OUTPUT + 1);
    localparam int DEC_RELOAD = (CLKS_PER_OUTPUT > 1) ? CLKS_PER_OUTPUT - 2 : 0;
    localparam int TAP_REACH  = 2 ** ($bits(tapIndex_t) - 1);  // widest positive tap plus one

    sampleAddr_t       wrAddr;
    sampleAddr_t       rdAddr;
    sampleAddr_t       sofAddress;
    sampleAddr_t       fillLevel;
    sampleAddr_t       tapAddr0;
    sampleAddr_t       tapAddr1;
    iqSample_t         tapData0;
    iqSample_t         tapData1;
    logic              writeEnable;
    logic              frameSeen;
    logic              estimatesReady;
    logic              trellisRun;     // from start of trellis to the last symbol
    logic [WARM_W-1:0] warmCount;
    alignState_e       state;
    logic [DEC_W-1:0]  decimationCount;
    logic [1:0]        outputCount;
    symbolIndex_t      symbolCount;
    logic              haveData;
    logic              readFire;
    logic              frameDone;

    assign writeEnable = clkEn && valid;
    assign fillLevel   = wrAddr - rdAddr;

    // right after alignment the read pointer runs ahead of the writes,
    // so wait until the widest positive tap is written as well
    assign haveData = !fillLevel[`ADDR_WIDTH-1] && (fillLevel > sampleAddr_t'(TAP_REACH));

    assign frameDone = tapStrobe && interpolate
                       && (symbolCount == symbolIndex_t'(`SYMBOLS_PER_FRAME - 1));
    assign readFire  = trellisRun && (warmCount == '0) && (state == waitValid)
                       && haveData && !frameDone;

    // frame and estimate flags, one start of trellis per frame
    always_ff @(posedge clk) begin
        if (reset) begin
            frameSeen      <= 1'b0;
            estimatesReady <= 1'b0;
            startOfTrellis <= 1'b0;
        end else if (clkEn) begin
            if (startOfFrame) begin
                frameSeen <= 1'b1;
            end else if (startOfTrellis) begin
                frameSeen <= 1'b0;
            end
            if (estimatesDone) begin
                estimatesReady <= 1'b1;
            end else if (startOfTrellis) begin
                estimatesReady <= 1'b0;
            end
            // a frame still being read holds off the next one
            startOfTrellis <= frameSeen && estimatesReady && !startOfTrellis && !trellisRun;
        end
    end

    // first data sample of the next frame
    always_ff @(posedge clk) begin
        if (clkEn && startOfFrame) begin
            sofAddress <= wrAddr + sampleAddr_t'(`PILOT_SAMPLES_PER_FRAME)
                          - sampleAddr_t'(startOffset);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrAddr <= '0;
            rdAddr <= '0;
            full   <= 1'b0;
        end else if (clkEn) begin
            if (valid) begin
                wrAddr <= wrAddr + 1'b1;
                full   <= ((wrAddr + 1'b1) == rdAddr) && !readFire;  // overwrite goes on
            end
            if (startOfTrellis) begin
                rdAddr <= sofAddress;   // skip the pilot and anything before it
            end else if (readFire) begin
                rdAddr <= rdAddr + 1'b1;
            end
        end
    end

    // read pacing, warm-up and symbol counting, all cleared after the last symbol
    always_ff @(posedge clk) begin
        if (reset || (clkEn && frameDone)) begin
            trellisRun      <= 1'b0;
            warmCount       <= '0;
            state           <= waitValid;
            decimationCount <= '0;
            outputCount     <= '0;
            symbolCount     <= '0;
            tapStrobe       <= 1'b0;
            interpolate     <= 1'b0;
        end else if (clkEn) begin
            if (startOfTrellis) begin
                trellisRun <= 1'b1;
                warmCount  <= WARM_W'(`TRELLIS_INIT_CYCLES);
            end else if (warmCount != '0) begin
                warmCount <= warmCount - 1'b1;
            end

            case (state)
                waitValid: begin
                    if (readFire && (CLKS_PER_OUTPUT > 1)) begin
                        state           <= waitDecimation;
                        decimationCount <= DEC_W'(DEC_RELOAD);
                    end
                end
                waitDecimation: begin
                    if (decimationCount == '0) begin
                        state <= waitValid;
                    end else begin
                        decimationCount <= decimationCount - 1'b1;
                    end
                end
            endcase

            // RAM data shows up one enabled cycle after the read
            tapStrobe   <= readFire;
            interpolate <= readFire && (outputCount == 2'd2);  // outputs 3, 7, 11 ...
            if (readFire) begin
                outputCount <= outputCount + 1'b1;
            end
            if (tapStrobe && interpolate) begin
                symbolCount <= symbolCount + 1'b1;
            end
        end
    end

    // signed tap offsets, wrapping inside the RAM
    assign tapAddr0 = rdAddr + sampleAddr_t'(tapIndex0);
    assign tapAddr1 = rdAddr + sampleAddr_t'(tapIndex1);

    dualReadSampleRam i_sampleRam (
        .clk         (clk),
        .clkEn       (clkEn),
        .writeEnable (writeEnable),
        .writeAddr   (wrAddr),
        .readAddrA   (tapAddr0),
        .readAddrB   (tapAddr1),
        .writeData   (sampleIn),
        .readDataA   (tapData0),
        .readDataB   (tapData1)
    );

    assign taps = '{tap0: tapData0, tap1: tapData1};

endmodule

`default_nettype wire

//--- logic/pilotFrameTimer.sv
`default_nettype none
`include "trellisFront_defines.svh"

module pilotFrameTimer (
    input  wire  clk,
    input  wire  reset,
    input  wire  clkEn,
    input  wire  valid,
    output logic startOfFrame,
    output logic estimatesDone
);

    localparam int FRAME_CNT_W = $clog2(`FRAME_SAMPLES);
    localparam int EST_CNT_W   = $clog2(`ESTIMATE_DELAY + 1);

    logic [FRAME_CNT_W-1:0] sampleCount;    // samples already seen in this frame
    logic [EST_CNT_W-1:0]   estimateCount;  // zero while no estimate is pending
    logic                   sampleTick;
    logic                   frameMark;
    logic                   estimateMark;

    assign sampleTick = clkEn && valid;

    // last sample of a frame, sample n with n a multiple of FRAME_SAMPLES
    assign frameMark    = (sampleCount == FRAME_CNT_W'(`FRAME_SAMPLES - 1));
    assign estimateMark = (estimateCount == EST_CNT_W'(1));

    // both strobes sit in the enabled cycle of the matching sample
    assign startOfFrame  = sampleTick && frameMark;
    assign estimatesDone = sampleTick && estimateMark;

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCount <= '0;
        end else if (sampleTick) begin
            if (frameMark) begin
                sampleCount <= '0;
            end else begin
                sampleCount <= sampleCount + 1'b1;
            end
        end
    end

    // countdown started at each frame mark,
    // reaches one on the ESTIMATE_DELAY-th sample after it
    always_ff @(posedge clk) begin
        if (reset) begin
            estimateCount <= '0;
        end else if (sampleTick) begin
            if (frameMark) begin
                estimateCount <= EST_CNT_W'(`ESTIMATE_DELAY);
            end else if (estimateCount != '0) begin
                estimateCount <= estimateCount - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tapCombiner.sv
`default_nettype none

module tapCombiner (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             clkEn,
    input  wire  trellisFrontPkg::tapPair_t taps,
    input  wire                             tapStrobe,
    input  wire                             interpolate,
    input  wire                             startOfTrellis,
    output trellisFrontPkg::trellisSymbol_t symbolOut,
    output logic                            symbolStrobe
);
    import trellisFrontPkg::*;

    symbolIndex_t symbolCount;  // interpolated symbols so far in this frame

    always_ff @(posedge clk) begin
        if (reset) begin
            symbolStrobe <= 1'b0;
            symbolCount  <= '0;
        end else if (clkEn) begin
            symbolStrobe <= tapStrobe;   // one enabled cycle behind the taps
            if (startOfTrellis) begin
                symbolCount <= '0;
            end else if (tapStrobe && interpolate) begin
                symbolCount <= symbolCount + 1'b1;
            end
        end
    end

    // sign-extend both taps before adding so the sum cannot wrap
    always_ff @(posedge clk) begin
        if (clkEn && tapStrobe) begin
            symbolOut.sumRe       <= softSum_t'(taps.tap0.re) + softSum_t'(taps.tap1.re);
            symbolOut.sumIm       <= softSum_t'(taps.tap0.im) + softSum_t'(taps.tap1.im);
            symbolOut.symbolIndex <= symbolCount;
            symbolOut.interpolate <= interpolate;
        end
    end

endmodule

`default_nettype wire

//--- logic/trellisFrontEnd.sv
`default_nettype none

module trellisFrontEnd #(
    parameter int CLKS_PER_OUTPUT = 2
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              clkEn,
    input  wire                              valid,
    input  wire  trellisFrontPkg::iqSample_t sampleIn,
    input  wire  trellisFrontPkg::tapIndex_t startOffset,
    input  wire  trellisFrontPkg::tapIndex_t tapIndex0,
    input  wire  trellisFrontPkg::tapIndex_t tapIndex1,
    output trellisFrontPkg::trellisSymbol_t  symbolOut,
    output logic                             symbolStrobe,
    output logic                             full
);
    import trellisFrontPkg::*;

    logic     startOfFrame;
    logic     estimatesDone;
    tapPair_t taps;
    logic     tapStrobe;
    logic     interpolate;
    logic     startOfTrellis;

    // frame marks counted from the incoming samples
    pilotFrameTimer i_timer (
        .clk           (clk),
        .reset         (reset),
        .clkEn         (clkEn),
        .valid         (valid),
        .startOfFrame  (startOfFrame),
        .estimatesDone (estimatesDone)
    );

    frameAlignment #(
        .CLKS_PER_OUTPUT (CLKS_PER_OUTPUT)
    ) i_align (
        .clk            (clk),
        .reset          (reset),
        .clkEn          (clkEn),
        .valid          (valid),
        .startOfFrame   (startOfFrame),
        .estimatesDone  (estimatesDone),
        .sampleIn       (sampleIn),
        .startOffset    (startOffset),
        .tapIndex0      (tapIndex0),
        .tapIndex1      (tapIndex1),
        .taps           (taps),
        .tapStrobe      (tapStrobe),
        .interpolate    (interpolate),
        .startOfTrellis (startOfTrellis),
        .full           (full)
    );

    tapCombiner i_combiner (
        .clk            (clk),
        .reset          (reset),
        .clkEn          (clkEn),
        .taps           (taps),
        .tapStrobe      (tapStrobe),
        .interpolate    (interpolate),
        .startOfTrellis (startOfTrellis),
        .symbolOut      (symbolOut),
        .symbolStrobe   (symbolStrobe)
    );

endmodule

`default_nettype wire

//--- logic/trellisFrontPkg.sv
`default_nettype none
`include "trellisFront_defines.svh"

package trellisFrontPkg;

    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [`ADDR_WIDTH-1:0]          sampleAddr_t;
    typedef logic signed [3:0]               tapIndex_t;     // tap offset and start offset
    typedef logic signed [`SAMPLE_WIDTH:0]   softSum_t;      // one bit of growth for the sum
    typedef logic [9:0]                      symbolIndex_t;

    // one complex sample, also the RAM word
    typedef struct packed {
        sample_t re;
        sample_t im;
    } iqSample_t;

    typedef struct packed {
        iqSample_t tap0;
        iqSample_t tap1;
    } tapPair_t;

    typedef struct packed {
        softSum_t     sumRe;
        softSum_t     sumIm;
        symbolIndex_t symbolIndex;
        logic         interpolate;
    } trellisSymbol_t;

    typedef enum logic {waitValid, waitDecimation} alignState_e;

endpackage

`default_nettype wire

//--- logic/trellisFront_defines.svh
`ifndef TRELLIS_FRONT_DEFINES_SVH
`define TRELLIS_FRONT_DEFINES_SVH

// width of one I or Q component
`define SAMPLE_WIDTH 18

// sample RAM address width, 32k words of buffering
`define ADDR_WIDTH 15

`define FRAME_SAMPLES 4096            // valid samples between frame marks
`define PILOT_SAMPLES_PER_FRAME 256   // frame mark to first data sample

// valid samples after a frame mark until the channel estimates are ready
`define ESTIMATE_DELAY 64

`define TRELLIS_INIT_CYCLES 128       // enabled cycles of trellis warm-up

// interpolated symbols handed to the trellis per frame
`define SYMBOLS_PER_FRAME 800

`endif

//--- testbench/trellisFrontEndTb.sv
`default_nettype none
`include "trellisFront_defines.svh"

module trellisFrontEndTb;
    import trellisFrontPkg::*;

    localparam int CLKS_PER_OUTPUT = 2;
    // the 800th interpolated output is the third of its group of four
    localparam int OUTPUTS_PER_FRAME = 4 * `SYMBOLS_PER_FRAME - 1;
    // two frames of reads after the first realignment, one more frame
    // mark for the overflow run, and a factor of two for clkEn gaps
    localparam int TIMEOUT_CYCLES = 2 * (3 * `FRAME_SAMPLES + `PILOT_SAMPLES_PER_FRAME
                                    + 2 * (OUTPUTS_PER_FRAME * CLKS_PER_OUTPUT
                                    + `TRELLIS_INIT_CYCLES));

    logic           clk;
    logic           reset;
    logic           clkEn;
    logic           valid;
    iqSample_t      sampleIn;
    tapIndex_t      startOffset;
    tapIndex_t      tapIndex0;
    tapIndex_t      tapIndex1;
    trellisSymbol_t symbolOut;
    logic           symbolStrobe;
    logic           full;

    iqSample_t      modelMem [2 ** `ADDR_WIDTH];   // written samples by write address
    sampleAddr_t    frameSof [16];                 // expected first data address per frame
    int             samplesWritten = 0;
    trellisSymbol_t frameSymbols [$];
    int             frameGaps [$];                 // enabled cycles before each symbol
    int             enabledSinceStrobe = 0;
    int             cycleCount = 0;
    integer         seed = 32'h540a;

    trellisFrontEnd #(
        .CLKS_PER_OUTPUT (CLKS_PER_OUTPUT)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .clkEn        (clkEn),
        .valid        (valid),
        .sampleIn     (sampleIn),
        .startOffset  (startOffset),
        .tapIndex0    (tapIndex0),
        .tapIndex1    (tapIndex1),
        .symbolOut    (symbolOut),
        .symbolStrobe (symbolStrobe),
        .full         (full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic iqSample_t makeSample(input int n);
        iqSample_t s;
        s.re = sample_t'(n);
        s.im = sample_t'(-3 * n);
        return s;
    endfunction

    function automatic longint tapSum(input sampleAddr_t base, input tapIndex_t t0,
                                      input tapIndex_t t1, input bit imag);
        iqSample_t a;
        iqSample_t b;
        a = modelMem[base + sampleAddr_t'(t0)];
        b = modelMem[base + sampleAddr_t'(t1)];
        if (imag) begin
            return longint'(a.im) + longint'(b.im);
        end
        return longint'(a.re) + longint'(b.re);
    endfunction

    // sample stream and reference model, valid stays high after reset
    always @(posedge clk) begin : driveSamples
        int nextNumber;
        nextNumber = samplesWritten + 1;
        if (reset) begin
            samplesWritten <= 0;
            nextNumber = 1;
        end else if (clkEn && valid) begin
            modelMem[sampleAddr_t'(samplesWritten)] <= sampleIn;
            samplesWritten <= samplesWritten + 1;
            if ((samplesWritten + 1) % `FRAME_SAMPLES == 0) begin  // frame mark
                frameSof[((samplesWritten + 1) / `FRAME_SAMPLES) % 16] <=
                    sampleAddr_t'(samplesWritten + `PILOT_SAMPLES_PER_FRAME)
                    - sampleAddr_t'(startOffset);
            end
            nextNumber = samplesWritten + 2;
        end
        clkEn    <= ($random(seed) & 7) != 0;   // about one low cycle in eight
        valid    <= 1'b1;
        sampleIn <= makeSample(nextNumber);
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_chk.failCount != 0) begin
            $display("A bound assertion on the DUT strobes failed");
            $display("Checks failed");
            $fatal(1, "bound assertion failure");
        end
    end

    task automatic failRun();
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input longint expected, input longint actual);
        assert (actual == expected) else begin
            $display("MISMATCH at time %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            failRun();
        end
    endtask

    task automatic collectSymbols(input int count);
        int got;
        got = 0;
        while (got < count) begin
            @(posedge clk);
            if (clkEn) begin
                enabledSinceStrobe++;
            end
            if (clkEn && symbolStrobe) begin
                frameSymbols.push_back(symbolOut);
                frameGaps.push_back(enabledSinceStrobe);
                enabledSinceStrobe = 0;
                got++;
            end
        end
    endtask

    task automatic resetQuiet();
        repeat (5) begin
            @(posedge clk);
            checkValue("symbolStrobe", 0, symbolStrobe);
            checkValue("full", 0, full);
        end
        reset <= 1'b0;
        while (samplesWritten < `FRAME_SAMPLES) begin
            @(posedge clk);
            checkValue("symbolStrobe", 0, symbolStrobe);
            checkValue("full", 0, full);
        end
    endtask

    task automatic frameAlignmentTest();
        sampleAddr_t sof;
        iqSample_t   first;
        frameSymbols.delete();
        frameGaps.delete();
        collectSymbols(1);
        sof   = frameSof[1];
        first = modelMem[sof];
        checkValue("symbolOut.sumRe", 2 * longint'(first.re), frameSymbols[0].sumRe);
        checkValue("symbolOut.sumIm", 2 * longint'(first.im), frameSymbols[0].sumIm);
        startOffset <= 4'sd3;  // frame 1 address is taken, frame 2 mark still ahead
        collectSymbols(OUTPUTS_PER_FRAME - 1);
        for (int k = 1; k < OUTPUTS_PER_FRAME; k++) begin
            checkValue("symbolOut.sumRe", tapSum(sof + sampleAddr_t'(k), 0, 0, 1'b0),
                       frameSymbols[k].sumRe);
            checkValue("symbolOut.sumIm", tapSum(sof + sampleAddr_t'(k), 0, 0, 1'b1),
                       frameSymbols[k].sumIm);
        end
    endtask

    task automatic endOfFrameTest();
        tapIndex0 <= -4'sd2;   // frame 2 reads wait for the warm-up
        tapIndex1 <= 4'sd1;
        frameSymbols.delete();
        frameGaps.delete();
        collectSymbols(1);
        assert (frameGaps[0] > `TRELLIS_INIT_CYCLES) else begin
            $display("A symbol came %0d enabled cycles after the end of frame 1, inside warm-up",
                     frameGaps[0]);
            failRun();
        end
        checkValue("symbolOut.symbolIndex", 0, frameSymbols[0].symbolIndex);
    endtask

    task automatic tapOffsetTest();
        sampleAddr_t sof;
        collectSymbols(OUTPUTS_PER_FRAME - 1);
        sof = frameSof[2];
        for (int k = 0; k < OUTPUTS_PER_FRAME; k++) begin
            checkValue("symbolOut.sumRe", tapSum(sof + sampleAddr_t'(k), -4'sd2, 4'sd1, 1'b0),
                       frameSymbols[k].sumRe);
            checkValue("symbolOut.sumIm", tapSum(sof + sampleAddr_t'(k), -4'sd2, 4'sd1, 1'b1),
                       frameSymbols[k].sumIm);
        end
    endtask

    task automatic decimationTest();
        int interpolated;
        interpolated = 0;
        for (int k = 0; k < OUTPUTS_PER_FRAME; k++) begin
            checkValue("symbolOut.interpolate", (k % 4) == 2, frameSymbols[k].interpolate);
            checkValue("symbolOut.symbolIndex", (k + 1) / 4, frameSymbols[k].symbolIndex);
            if (frameSymbols[k].interpolate) begin
                interpolated++;
            end
            if (k > 0) begin
                assert (frameGaps[k] >= CLKS_PER_OUTPUT) else begin
                    $display("Symbols %0d and %0d were only %0d enabled cycles apart",
                             k - 1, k, frameGaps[k]);
                    failRun();
                end
            end
        end
        checkValue("interpolated symbols per frame", `SYMBOLS_PER_FRAME, interpolated);
    endtask

    // after a fresh reset the realigned read pointer sits ahead of the
    // writes, so the writer runs into it before any read is made
    task automatic overflowTest();
        int waited;
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        while (!full) begin
            @(posedge clk);
            waited++;
            assert (waited <= 2 ** `ADDR_WIDTH) else begin
                $display("full never rose within %0d cycles of writes", waited);
                failRun();
            end
        end
        checkValue("samples written when full rose", frameSof[1], samplesWritten);
    endtask

    initial begin
        reset       = 1'b1;
        clkEn       = 1'b0;
        valid       = 1'b0;
        sampleIn    = '0;
        startOffset = '0;
        tapIndex0   = '0;
        tapIndex1   = '0;
        resetQuiet();
        frameAlignmentTest();
        endOfFrameTest();
        tapOffsetTest();
        decimationTest();
        overflowTest();
        @(negedge clk);
        if (i_dut.i_chk.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/trellisFrontEnd_chk.sv
`default_nettype none

module trellisFrontEndChk #(
    parameter int CLKS_PER_OUTPUT = 2
) (
    input wire clk,
    input wire reset,
    input wire clkEn,
    input wire symbolStrobe,
    input wire full,
    input wire tapStrobe,
    input wire startOfTrellis
);

    int   enabledSinceStrobe;  // saturates at CLKS_PER_OUTPUT
    logic strobeSeen;
    int   failCount = 0;       // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            enabledSinceStrobe <= 0;
            strobeSeen         <= 1'b0;
        end else if (clkEn) begin
            if (symbolStrobe) begin
                enabledSinceStrobe <= 1;
                strobeSeen         <= 1'b1;
            end else if (enabledSinceStrobe < CLKS_PER_OUTPUT) begin
                enabledSinceStrobe <= enabledSinceStrobe + 1;
            end
        end
    end

    // registered strobes only change on enabled edges
    assert property (@(posedge clk) disable iff (reset) $rose(symbolStrobe) |-> $past(clkEn))
        else begin
            failCount++;
            $error("symbolStrobe rose after a disabled cycle");
        end
    assert property (@(posedge clk) disable iff (reset) $rose(tapStrobe) |-> $past(clkEn))
        else begin
            failCount++;
            $error("tapStrobe rose after a disabled cycle");
        end
    assert property (@(posedge clk) disable iff (reset) $rose(startOfTrellis) |-> $past(clkEn))
        else begin
            failCount++;
            $error("startOfTrellis rose after a disabled cycle");
        end
    assert property (@(posedge clk) disable iff (reset) $rose(full) |-> $past(clkEn))
        else begin
            failCount++;
            $error("full rose after a disabled cycle");
        end

    assert property (@(posedge clk) disable iff (reset)
        (clkEn && symbolStrobe && strobeSeen) |-> (enabledSinceStrobe >= CLKS_PER_OUTPUT))
        else begin
            failCount++;
            $error("two symbol strobes closer than the decimation count");
        end

endmodule

bind trellisFrontEnd trellisFrontEndChk #(
    .CLKS_PER_OUTPUT (CLKS_PER_OUTPUT)
) i_chk (
    .clk            (clk),
    .reset          (reset),
    .clkEn          (clkEn),
    .symbolStrobe   (symbolStrobe),
    .full           (full),
    .tapStrobe      (tapStrobe),
    .startOfTrellis (startOfTrellis)
);

`default_nettype wire
